/* rtl/isa_pkg.sv */
/*
 * Instruction set of the pin-fed 8-bit register machine
 * Opcode classes, output selects and the 16-bit instruction layout
 */

package isa_pkg;

    // Field widths
    localparam int OPCODE_W   = 2;
    localparam int REG_ADDR_W = 3;   // Eight registers
    localparam int FUNCT3_W   = 3;
    localparam int FUNCT2_W   = 2;
    localparam int IMM_W      = 5;   // Short immediate in bits 12:8
    localparam int INSTR_W    = 16;  // uio_in high byte, ui_in low byte

    // Instruction classes in bits 1:0
    typedef enum logic [OPCODE_W-1:0] {
        OP_R   = 2'b00,  // Register-register ALU op
        OP_I   = 2'b01,  // Register-immediate ALU op
        OP_L   = 2'b10,  // Load 8-bit immediate
        OP_OUT = 2'b11   // Drive uo_out, no write
    } opcode_e;

    // Output kinds carried in funct3 of OP_OUT
    // Codes not listed here drive zero
    typedef enum logic [FUNCT3_W-1:0] {
        OUT_REG = 3'b000,  // rs1 value
        OUT_CMP = 3'b011,  // Equality flag in bit 0
        OUT_ALU = 3'b111   // ALU result
    } out_sel_e;

    // Instruction fields from high to low bits
    //   15:13 funct3
    //   12:11 funct2
    //   10:8  rs2
    //    7:5  rs1
    //    4:2  rd
    //    1:0  opcode
    // Bits 12:8 double as the short immediate
    // For OP_L funct3 supplies the top three immediate bits
    typedef struct packed {
        logic [FUNCT3_W-1:0]   funct3;  // ALU op low bits or output select
        logic [FUNCT2_W-1:0]   funct2;  // Bit 0 alt op, bit 1 compare invert
        logic [REG_ADDR_W-1:0] rs2;
        logic [REG_ADDR_W-1:0] rs1;
        logic [REG_ADDR_W-1:0] rd;
        opcode_e               opcode;
    } instr_t;

endpackage

/* rtl/core_pkg.sv */
/*
 * Core-internal definitions
 * Data width, ALU operation codes and the decoded control bundle
 */

package core_pkg;

    localparam int DATA_W   = 8;  // Register and datapath width
    localparam int NUM_REGS = 8;  // r0 is an ordinary register

    // ALU operations
    // Low three bits come straight from funct3, bit 3 is the alternate bit
    // Codes 1010 to 1111 act like their bit-3-clear forms
    typedef enum logic [3:0] {
        ALU_ADD   = 4'b0000,
        ALU_SLL   = 4'b0001,
        ALU_AND   = 4'b0010,
        ALU_XOR   = 4'b0011,
        ALU_OR    = 4'b0100,
        ALU_SLT   = 4'b0101,  // Signed less-than
        ALU_SLTU  = 4'b0110,  // Unsigned less-than
        ALU_PASSB = 4'b0111,  // Operand b straight through
        ALU_SUB   = 4'b1000,
        ALU_SRL   = 4'b1001
    } alu_op_e;

    // Decoded control shared by the register file and the execution unit
    typedef struct packed {
        logic [isa_pkg::REG_ADDR_W-1:0] rs1;
        logic [isa_pkg::REG_ADDR_W-1:0] rs2;
        logic [isa_pkg::REG_ADDR_W-1:0] rd;
        logic                           we;       // Register write this cycle
        alu_op_e                        alu_op;
        logic                           use_imm;  // Operand b from imm
        logic                           is_load;  // Write back imm
        logic [DATA_W-1:0]              imm;
        logic                           is_out;   // OP_OUT drives uo_out
        isa_pkg::out_sel_e              out_sel;
        logic                           cmp_inv;  // Invert equality flag
    } dec_t;

endpackage

/* rtl/alu.sv */
/*
 * ALU
 * Combinational 8-bit add/sub, shifts, logic ops and compares
 * Zero flag feeds the equality output of the core
 */

`timescale 1ns/10ps
`default_nettype none

module alu (
    input  core_pkg::alu_op_e             alu_op,
    input  logic [core_pkg::DATA_W-1:0]   a,
    input  logic [core_pkg::DATA_W-1:0]   b,
    output logic [core_pkg::DATA_W-1:0]   y,
    output logic                          zero
);

    core_pkg::alu_op_e base_op;  // Op with bit 3 cleared
    logic              alt;      // Alternate form select
    logic [2:0]        shamt;
    logic              lt_s;
    logic              lt_u;

    // Bit 3 only matters for ADD and SLL, everything else ignores it
    assign base_op = core_pkg::alu_op_e'({1'b0, alu_op[2:0]});
    assign alt     = alu_op[3];

    assign shamt = b[2:0];  // Shift range 0 to 7

    assign lt_s = ($signed(a) < $signed(b));
    assign lt_u = (a < b);

    always_comb begin
        unique case (base_op)
            core_pkg::ALU_ADD: begin
                y = alt ? (a - b) : (a + b);  // Carry dropped
            end
            core_pkg::ALU_SLL: begin
                y = alt ? (a >> shamt) : (a << shamt);  // SRL is logical
            end
            core_pkg::ALU_AND:   y = a & b;
            core_pkg::ALU_XOR:   y = a ^ b;  // Zero when equal
            core_pkg::ALU_OR:    y = a | b;
            core_pkg::ALU_SLT:   y = {{(core_pkg::DATA_W - 1){1'b0}}, lt_s};
            core_pkg::ALU_SLTU:  y = {{(core_pkg::DATA_W - 1){1'b0}}, lt_u};
            core_pkg::ALU_PASSB: y = b;
            default:             y = '0;  // Unreachable with bit 3 clear
        endcase
    end

    assign zero = (y == '0);

endmodule

/* rtl/instr_decode.sv */
/*
 * Instruction decoder
 * Splits the pin instruction into fields and derives the write enable,
 * ALU operation, immediate and output selection. Purely combinational
 */

`timescale 1ns/10ps
`default_nettype none

module instr_decode (
    input  isa_pkg::instr_t instr,
    output core_pkg::dec_t  dec
);

    logic [isa_pkg::IMM_W-1:0] imm_short;  // Bits 12:8
    logic                      alu_alt;    // ALU op bit 3
    logic                      is_i_type;
    logic                      is_l_type;

    // Short immediate shares bits with funct2 and rs2
    assign imm_short = {instr.funct2, instr.rs2};

    assign is_i_type = (instr.opcode == isa_pkg::OP_I);
    assign is_l_type = (instr.opcode == isa_pkg::OP_L);

    // I-type has no room for the alternate bit
    assign alu_alt = is_i_type ? 1'b0 : instr.funct2[0];

    always_comb begin
        // Register addresses pass straight through
        dec.rs1 = instr.rs1;
        dec.rs2 = instr.rs2;
        dec.rd  = instr.rd;

        // Every class but OP_OUT writes rd
        dec.we = (instr.opcode != isa_pkg::OP_OUT);

        dec.alu_op  = core_pkg::alu_op_e'({alu_alt, instr.funct3});
        dec.use_imm = is_i_type;
        dec.is_load = is_l_type;

        // Load takes funct3 as the top bits, otherwise zero-extend
        if (is_l_type) begin
            dec.imm = {instr.funct3, imm_short};
        end else begin
            dec.imm = {{(core_pkg::DATA_W - isa_pkg::IMM_W){1'b0}}, imm_short};
        end

        // Output control
        dec.is_out  = (instr.opcode == isa_pkg::OP_OUT);
        dec.out_sel = isa_pkg::out_sel_e'(instr.funct3);  // Undefined codes kept
        dec.cmp_inv = instr.funct2[1];
    end

    // An I-type op must never reach SUB or SRL, and output ops never write
    always_comb begin
        if (instr.opcode == isa_pkg::OP_I) begin
            assert final (dec.alu_op[3] == 1'b0)
                else $error("I-type decode carries alternate ALU bit");
        end
        if (dec.is_out) begin
            assert final (!dec.we)
                else $error("Output instruction decoded with write enable");
        end
    end

endmodule

/* rtl/reg_file.sv */
/*
 * Register file
 * Eight 8-bit registers, two combinational reads, one write per clock
 * Synchronous active-low reset clears every entry
 */

`timescale 1ns/10ps
`default_nettype none

module reg_file (
    input  logic                          clk,
    input  logic                          rst_n,
    input  core_pkg::dec_t                dec,
    input  logic [core_pkg::DATA_W-1:0]   wr_data,
    output logic [core_pkg::DATA_W-1:0]   rd_data1,
    output logic [core_pkg::DATA_W-1:0]   rd_data2
);

    logic [core_pkg::DATA_W-1:0] regs [core_pkg::NUM_REGS];

    // Write at the edge ending the instruction's cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            // Clear all, no write during reset
            for (int i = 0; i < core_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (dec.we) begin
            regs[dec.rd] <= wr_data;  // r0 writable like any other
        end
    end

    // Asynchronous reads, a write shows up next cycle
    assign rd_data1 = regs[dec.rs1];  // Operand a / OUT_REG source
    assign rd_data2 = regs[dec.rs2];  // Operand b for R-type

    // Write-back data comes from the execution unit and must be fully known
    assert property (@(posedge clk) disable iff (!rst_n)
        dec.we |-> !$isunknown(wr_data))
        else $error("Register write with unknown data");

    // A written register reads back the written value in the next cycle
    assert property (@(posedge clk) disable iff (!rst_n)
        dec.we ##1 (rst_n && dec.rs1 == $past(dec.rd))
        |-> rd_data1 == $past(wr_data))
        else $error("Register read-back mismatch after write");

endmodule

/* rtl/exec_unit.sv */
/*
 * Execution unit
 * Picks ALU operands, forms the write-back value and selects the
 * byte driven on uo_out for output instructions
 */

`timescale 1ns/10ps
`default_nettype none

module exec_unit (
    input  core_pkg::dec_t                dec,
    input  logic [core_pkg::DATA_W-1:0]   rd_data1,
    input  logic [core_pkg::DATA_W-1:0]   rd_data2,
    output logic [core_pkg::DATA_W-1:0]   wr_data,
    output logic [core_pkg::DATA_W-1:0]   result
);

    logic [core_pkg::DATA_W-1:0] op_b;
    logic [core_pkg::DATA_W-1:0] alu_y;
    logic                        alu_zero;

    assign op_b = dec.use_imm ? dec.imm : rd_data2;  // I-type takes imm

    alu i_alu (
        .alu_op (dec.alu_op),
        .a      (rd_data1),
        .b      (op_b),
        .y      (alu_y),
        .zero   (alu_zero)
    );

    // Loads bypass the ALU
    assign wr_data = dec.is_load ? dec.imm : alu_y;

    always_comb begin
        result = '0;  // Non-output and undefined selects
        if (dec.is_out) begin
            case (dec.out_sel)
                isa_pkg::OUT_REG: result = rd_data1;
                isa_pkg::OUT_CMP: result = {{(core_pkg::DATA_W - 1){1'b0}},
                                            alu_zero ^ dec.cmp_inv};
                isa_pkg::OUT_ALU: result = alu_y;
                default:          result = '0;
            endcase
        end
    end

    // uo_out stays quiet on every cycle that writes a register
    always_comb begin
        if (!dec.is_out) begin
            assert final (result == '0)
                else $error("Output byte nonzero on a non-output instruction");
        end
    end

endmodule

/* rtl/tt_um_riscv_core.sv */
/*
 * Pin-fed 8-bit register machine, top level
 * One 16-bit instruction per clock from ui_in and uio_in
 */

`timescale 1ns/10ps
`default_nettype none

module tt_um_riscv_core (
    input  logic [7:0] ui_in,    // Instruction low byte
    output logic [7:0] uo_out,   // Output-type result
    input  logic [7:0] uio_in,   // Instruction high byte
    output logic [7:0] uio_out,
    output logic [7:0] uio_oe,   // All bidirectional pins are inputs
    input  logic       ena,      // Always high when powered, unused
    input  logic       clk,
    input  logic       rst_n
);

    isa_pkg::instr_t             instr;
    core_pkg::dec_t              dec;
    logic [core_pkg::DATA_W-1:0] rd_data1;
    logic [core_pkg::DATA_W-1:0] rd_data2;
    logic [core_pkg::DATA_W-1:0] wr_data;

    // High byte on the IO pins, low byte on the dedicated inputs
    assign instr = isa_pkg::instr_t'({uio_in, ui_in});

    assign uio_out = '0;
    assign uio_oe  = '0;

    instr_decode i_instr_decode (
        .instr (instr),
        .dec   (dec)
    );

    reg_file i_reg_file (
        .clk      (clk),
        .rst_n    (rst_n),
        .dec      (dec),
        .wr_data  (wr_data),
        .rd_data1 (rd_data1),
        .rd_data2 (rd_data2)
    );

    exec_unit i_exec_unit (
        .dec      (dec),
        .rd_data1 (rd_data1),
        .rd_data2 (rd_data2),
        .wr_data  (wr_data),
        .result   (uo_out)
    );

endmodule

/* dv/tb_riscv_core.sv */
/*
 * Testbench for the pin-fed 8-bit register machine
 * LCG instructions driven on the pins, uo_out checked against a register model
 */

`timescale 1ns/10ps

module tb_riscv_core;

    localparam int CLK_PERIOD   = 10;
    localparam int RESET_CYCLES = 8;
    localparam int N_LOAD       = 24;
    localparam int N_R_PER_OP   = 4;    // Per alu_op code, all 16 codes
    localparam int N_OUT_ALU    = 16;
    localparam int N_IMM        = 32;
    localparam int N_CMP        = 16;
    localparam int N_UNDEF      = 8;
    localparam int N_STREAM     = 400;
    // Every issued instruction, read-backs included
    localparam int TOTAL_INSTR  = 8 + 2 * N_LOAD + 2 * 16 * N_R_PER_OP + 2 * N_OUT_ALU
                                + 2 * N_IMM + 3 * N_CMP + N_UNDEF + N_STREAM + 8;
    localparam int TIMEOUT_NS   = TOTAL_INSTR * CLK_PERIOD * 2 + RESET_CYCLES * CLK_PERIOD;
    localparam logic [14:0] UNDEF_SELS = {3'd6, 3'd5, 3'd4, 3'd2, 3'd1};  // Unused selects

    logic       clk;
    logic       rst_n;
    logic       ena;
    logic [7:0] ui_in;
    logic [7:0] uio_in;
    logic [7:0] uo_out;
    logic [7:0] uio_out;
    logic [7:0] uio_oe;

    logic [31:0]                 rng_state;
    logic [core_pkg::DATA_W-1:0] model_regs [core_pkg::NUM_REGS];  // Reference registers
    int err_count;
    int check_count;
    int test_num;
    int test_err_start;
    int tests_passed;
    int tests_failed;

    tt_um_riscv_core i_tt_um_riscv_core (
        .ui_in   (ui_in),
        .uo_out  (uo_out),
        .uio_in  (uio_in),
        .uio_out (uio_out),
        .uio_oe  (uio_oe),
        .ena     (ena),
        .clk     (clk),
        .rst_n   (rst_n)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // Watchdog
    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("*** TEST FAILED ***");
        $finish;
    end

    function automatic logic [31:0] rand32();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;  // LCG step
        return rng_state;
    endfunction

    function automatic logic [15:0] encode(input logic [2:0] f3, input logic [1:0] f2,
                                           input logic [2:0] rs2, input logic [2:0] rs1,
                                           input logic [2:0] rd, input logic [1:0] op);
        return {f3, f2, rs2, rs1, rd, op};
    endfunction

    // Load puts value bits 7:5 in funct3 and bits 4:0 in bits 12:8
    function automatic logic [15:0] load_of(input logic [2:0] rd, input logic [7:0] val);
        return encode(val[7:5], val[4:3], val[2:0], 3'd0, rd, isa_pkg::OP_L);
    endfunction

    function automatic logic [15:0] read_of(input logic [2:0] rs);
        return encode(isa_pkg::OUT_REG, 2'b00, 3'd0, rs, 3'd0, isa_pkg::OP_OUT);
    endfunction

    // Reference ALU where bit 3 only alters ADD and SLL
    function automatic logic [7:0] ref_alu(input logic [3:0] op, input logic [7:0] a,
                                           input logic [7:0] b);
        logic [7:0] y;
        case (op[2:0])
            3'd0:    y = op[3] ? a - b : a + b;
            3'd1:    y = op[3] ? a >> b[2:0] : a << b[2:0];
            3'd2:    y = a & b;
            3'd3:    y = a ^ b;
            3'd4:    y = a | b;
            3'd5:    y = {7'b0, $signed(a) < $signed(b)};
            3'd6:    y = {7'b0, a < b};
            default: y = b;  // Pass b
        endcase
        return y;
    endfunction

    // Expected uo_out from the current model registers
    function automatic logic [7:0] expected_out(input logic [15:0] ins);
        logic [7:0] a;
        logic [7:0] b;
        logic [7:0] y;
        logic [7:0] res;
        a   = model_regs[ins[7:5]];
        b   = model_regs[ins[10:8]];
        y   = ref_alu({ins[11], ins[15:13]}, a, b);
        res = 8'h00;
        if (ins[1:0] == isa_pkg::OP_OUT) begin
            case (ins[15:13])
                3'b000:  res = a;
                3'b011:  res = {7'b0, (y == 8'h00) ^ ins[12]};  // Equality, maybe inverted
                3'b111:  res = y;
                default: res = 8'h00;
            endcase
        end
        return res;
    endfunction

    // Register update at the rising edge
    function automatic void apply_write(input logic [15:0] ins);
        logic [7:0] a;
        logic [7:0] b;
        a = model_regs[ins[7:5]];
        b = model_regs[ins[10:8]];
        case (ins[1:0])
            isa_pkg::OP_R: model_regs[ins[4:2]] = ref_alu({ins[11], ins[15:13]}, a, b);
            isa_pkg::OP_I: model_regs[ins[4:2]] = ref_alu({1'b0, ins[15:13]}, a,
                                                          {3'b000, ins[12:8]});
            isa_pkg::OP_L: model_regs[ins[4:2]] = {ins[15:13], ins[12:8]};
            default: ;  // Output ops never write
        endcase
    endfunction

    // One instruction for one cycle, called just after a rising edge
    task automatic issue(input logic [15:0] ins);
        logic [7:0] exp;
        uio_in <= ins[15:8];
        ui_in  <= ins[7:0];
        @(negedge clk);
        exp = expected_out(ins);
        check_count++;
        if (uo_out !== exp) begin
            $display("Fail at %0t: uo_out for instr %h expected %h got %h",
                     $time, ins, exp, uo_out);
            err_count++;
        end
        if (uio_oe !== 8'h00 || uio_out !== 8'h00) begin
            $display("Fail at %0t: uio_oe/uio_out expected 00/00 got %h/%h",
                     $time, uio_oe, uio_out);
            err_count++;
        end
        @(posedge clk);
        apply_write(ins);
    endtask

    task automatic begin_test();
        test_num++;
        test_err_start = err_count;
    endtask

    task automatic end_test(input string name);
        if (err_count == test_err_start) begin
            tests_passed++;
            $display("Test %0d %s: passed", test_num, name);
        end else begin
            tests_failed++;
            $display("Test %0d %s: failed with %0d errors", test_num, name,
                     err_count - test_err_start);
        end
    endtask

    task automatic reset_reads();
        begin_test();
        for (int k = 0; k < core_pkg::NUM_REGS; k++) begin
            issue(read_of(3'(k)));  // All zero after reset
        end
        end_test("reset reads");
    endtask

    task automatic random_loads();
        logic [31:0] r;
        begin_test();
        for (int i = 0; i < N_LOAD; i++) begin
            r = rand32();
            issue(load_of(r[31:29], r[23:16]));
            issue(read_of(r[31:29]));
        end
        end_test("random loads");
    endtask

    task automatic rtype_sweep();
        logic [31:0] r;
        logic [3:0]  op;
        begin_test();
        for (int k = 0; k < 16; k++) begin
            op = 4'(k);
            for (int i = 0; i < N_R_PER_OP; i++) begin
                r = rand32();
                // funct2 bit 0 is the alternate bit, bit 1 random
                issue(encode(op[2:0], {r[31], op[3]}, r[30:28], r[27:25], r[24:22],
                             isa_pkg::OP_R));
                issue(read_of(r[24:22]));
            end
        end
        for (int i = 0; i < N_OUT_ALU; i++) begin
            r = rand32();
            issue(encode(isa_pkg::OUT_ALU, r[31:30], r[29:27], r[26:24], r[23:21],
                         isa_pkg::OP_OUT));
            issue(read_of(r[23:21]));  // rd field untouched
        end
        end_test("R-type sweep");
    endtask

    task automatic itype_sweep();
        logic [31:0] r;
        begin_test();
        for (int i = 0; i < N_IMM; i++) begin
            r = rand32();
            // Each funct3 sees passes with and without funct2 bit 0 set
            // which must not reach ALU bit 3
            issue(encode(3'(i >> 1), {r[28], 1'(i)}, r[27:25], r[24:22], r[21:19],
                         isa_pkg::OP_I));
            issue(read_of(r[21:19]));
        end
        end_test("I-type sweep");
    endtask

    task automatic compare_outputs();
        logic [31:0] r;
        logic [2:0]  ra;
        logic [2:0]  rb;
        logic [7:0]  va;
        logic [7:0]  vb;
        int          idx;
        begin_test();
        for (int i = 0; i < N_CMP; i++) begin
            r  = rand32();
            ra = r[31:29];
            rb = ra ^ (3'd1 + {1'b0, r[28:27]});    // Always a different register
            va = r[23:16];
            vb = i[0] ? va : va ^ {r[15:9], 1'b1};  // Equal on odd passes
            issue(load_of(ra, va));
            issue(load_of(rb, vb));
            // funct2 bit 1 inverts the flag on every other pair of passes
            // bit 0 picks XOR or its alternate code
            issue(encode(isa_pkg::OUT_CMP, {1'(i >> 1), r[7]}, rb, ra, 3'd0,
                         isa_pkg::OP_OUT));
        end
        for (int i = 0; i < N_UNDEF; i++) begin
            r   = rand32();
            idx = i % 5;
            issue(encode(UNDEF_SELS[3*idx +: 3], r[31:30], r[29:27], r[26:24], r[23:21],
                         isa_pkg::OP_OUT));
        end
        end_test("compare and undefined outputs");
    endtask

    task automatic mixed_stream();
        logic [31:0] r;
        begin_test();
        for (int i = 0; i < N_STREAM; i++) begin
            r = rand32();
            issue(r[31:16]);  // Any opcode, any fields
        end
        for (int k = 0; k < core_pkg::NUM_REGS; k++) begin
            issue(read_of(3'(k)));  // Final register sweep
        end
        end_test("mixed stream");
    endtask

    initial begin
        clk            = 1'b0;
        rst_n          = 1'b0;
        ena            = 1'b1;
        ui_in          = 8'h00;
        uio_in         = 8'h00;
        rng_state      = 32'h0885_4a64;
        err_count      = 0;
        check_count    = 0;
        test_num       = 0;
        test_err_start = 0;
        tests_passed   = 0;
        tests_failed   = 0;
        for (int k = 0; k < core_pkg::NUM_REGS; k++) begin
            model_regs[k] = '0;
        end

        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;

        reset_reads();
        random_loads();
        rtype_sweep();
        itype_sweep();
        compare_outputs();
        mixed_stream();

        $display("Summary: %0d tests passed, %0d tests failed, %0d checks, %0d errors",
                 tests_passed, tests_failed, check_count, err_count);
        if (err_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* list.f */
rtl/isa_pkg.sv
rtl/core_pkg.sv
rtl/alu.sv
rtl/instr_decode.sv
rtl/reg_file.sv
rtl/exec_unit.sv
rtl/tt_um_riscv_core.sv
dv/tb_riscv_core.sv

/* Makefile */
TB = tb_riscv_core

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -j 0 --top-module $(TB) -f list.f -Mdir obj_dir

run: build
	@out=$$(./obj_dir/V$(TB)); \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

lint:
	verilator --lint-only -Wall --timing --top-module $(TB) -f list.f

clean:
	rm -rf obj_dir
